// File: design/axil_regs_config.svh
// ====================
// AXI-Lite register peripheral configuration
// Address width, register map offsets and ID word
// ====================

`ifndef AXIL_REGS_CONFIG_SVH
`define AXIL_REGS_CONFIG_SVH

`define AXIL_ADDR_W       32

// Byte offsets of the register map
`define AXIL_ID_OFS       32'h0000_0000
`define AXIL_SCRATCH_OFS  32'h0000_0004
`define AXIL_SCRATCH_N    4
// Count word sits right after the last scratch word
`define AXIL_WCOUNT_OFS   (`AXIL_SCRATCH_OFS + 4 * `AXIL_SCRATCH_N)

`define AXIL_REGS_ID      32'hA51C_0100

`endif

// File: design/axil_regs_pkg.sv
// ====================
// AXI-Lite register peripheral types
// Request, result and response structs plus FSM state enums
// ====================

`include "axil_regs_config.svh"

package axil_regs_pkg;

   // AXI-Lite response codes, only the two the slave returns
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
      logic [31:0]             data;
      logic [3:0]              strb;
   } axil_wr_req_t;

   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
   } axil_rd_req_t;

   typedef struct packed {
      logic [31:0] data;
      axil_resp_e  resp;
   } axil_rd_res_t;

   // Write side capture states
   typedef enum logic [1:0] {
      WR_IDLE, WR_HAVE_AW, WR_HAVE_W, WR_WAIT_B
   } wr_state_e;

   typedef enum logic {RD_IDLE, RD_WAIT_R} rd_state_e;

endpackage

// File: design/axil_req_capture.sv
// ====================
// AXI-Lite request capture
// Accepts AW, W and AR beats in any order and hands
// each complete request on as a one-cycle strobe
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module axil_req_capture
   import axil_regs_pkg::*;
(
   input  logic                    axil_clk,
   input  logic                    rst,
   // Write address and data
   input  logic                    awvalid,
   input  logic [`AXIL_ADDR_W-1:0] awaddr,
   output logic                    awready,
   input  logic                    wvalid,
   input  logic [31:0]             wdata,
   input  logic [3:0]              wstrb,
   output logic                    wready,
   // Read address
   input  logic                    arvalid,
   input  logic [`AXIL_ADDR_W-1:0] araddr,
   output logic                    arready,
   // Responses taken by the master
   input  logic                    wr_done,
   input  logic                    rd_done,
   // Requests to the register file
   output logic                    wr_stb,
   output axil_wr_req_t            wr_req,
   output logic                    rd_stb,
   output axil_rd_req_t            rd_req
);

   wr_state_e wr_state;
   rd_state_e rd_state;
   logic      aw_hs;
   logic      w_hs;
   logic      ar_hs;

   // Each channel is open only until its own beat has been taken
   assign awready = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_W);
   assign wready  = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_AW);
   assign arready = (rd_state == RD_IDLE);

   assign aw_hs = awvalid && awready;
   assign w_hs  = wvalid && wready;
   assign ar_hs = arvalid && arready;

   // ====================
   // Write side FSM
   // ====================
   always_ff @(posedge axil_clk) begin
      if (rst) begin
         wr_state <= WR_IDLE;
         wr_stb   <= 1'b0;
      end else begin
         wr_stb <= 1'b0;
         case (wr_state)
            WR_IDLE: begin
               if (aw_hs && w_hs) begin
                  wr_state <= WR_WAIT_B;
                  wr_stb   <= 1'b1;
               end else if (aw_hs) begin
                  wr_state <= WR_HAVE_AW;
               end else if (w_hs) begin
                  wr_state <= WR_HAVE_W;
               end
            end
            WR_HAVE_AW: begin
               if (w_hs) begin
                  wr_state <= WR_WAIT_B;
                  wr_stb   <= 1'b1;
               end
            end
            WR_HAVE_W: begin
               if (aw_hs) begin
                  wr_state <= WR_WAIT_B;
                  wr_stb   <= 1'b1;
               end
            end
            WR_WAIT_B: begin
               if (wr_done) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   // ====================
   // Read side FSM
   // ====================
   always_ff @(posedge axil_clk) begin
      if (rst) begin
         rd_state <= RD_IDLE;
         rd_stb   <= 1'b0;
      end else begin
         rd_stb <= ar_hs;
         if (ar_hs) begin
            rd_state <= RD_WAIT_R;
         end else if (rd_state == RD_WAIT_R && rd_done) begin
            rd_state <= RD_IDLE;
         end
      end
   end

   // Request payload, held until the next beat of its channel
   always_ff @(posedge axil_clk) begin
      if (aw_hs) begin
         wr_req.addr <= awaddr;
      end
      if (w_hs) begin
         wr_req.data <= wdata;
         wr_req.strb <= wstrb;
      end
      if (ar_hs) begin
         rd_req.addr <= araddr;
      end
   end

endmodule

// File: design/axil_reg_file.sv
// ====================
// AXI-Lite register map
// ID word, byte-strobed scratch words and a count of
// accepted writes; bad accesses answer SLVERR
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module axil_reg_file
   import axil_regs_pkg::*;
(
   input  logic         axil_clk,
   input  logic         rst,
   input  logic         wr_stb,
   input  axil_wr_req_t wr_req,
   input  logic         rd_stb,
   input  axil_rd_req_t rd_req,
   output logic         wr_res_stb,
   output axil_resp_e   wr_resp,
   output logic         rd_res_stb,
   output axil_rd_res_t rd_res
);

   localparam int SCR_N  = `AXIL_SCRATCH_N;
   localparam int IDX_W  = (SCR_N > 1) ? $clog2(SCR_N) : 1;
   localparam int WORD_W = `AXIL_ADDR_W - 2;

   // Word addresses of the map
   localparam logic [WORD_W-1:0] ID_WORD  = WORD_W'(`AXIL_ID_OFS >> 2);
   localparam logic [WORD_W-1:0] SCR_WORD = WORD_W'(`AXIL_SCRATCH_OFS >> 2);
   localparam logic [WORD_W-1:0] CNT_WORD = WORD_W'(`AXIL_WCOUNT_OFS >> 2);

   logic [31:0]       scratch [SCR_N];
   logic [31:0]       wr_count;

   logic [WORD_W-1:0] wr_word;
   logic [WORD_W-1:0] wr_rel;
   logic              wr_scr_hit;
   logic [IDX_W-1:0]  wr_idx;

   logic [WORD_W-1:0] rd_word;
   logic [WORD_W-1:0] rd_rel;
   logic              rd_scr_hit;
   logic [IDX_W-1:0]  rd_idx;
   logic [31:0]       rd_data_c;
   axil_resp_e        rd_resp_c;

   // ====================
   // Address decode
   // ====================
   assign wr_word = wr_req.addr[`AXIL_ADDR_W-1:2];
   assign rd_word = rd_req.addr[`AXIL_ADDR_W-1:2];

   // Offset wraps below the base, so one compare covers both bounds
   assign wr_rel     = wr_word - SCR_WORD;
   assign wr_scr_hit = (wr_rel < WORD_W'(SCR_N));
   assign wr_idx     = wr_rel[IDX_W-1:0];

   assign rd_rel     = rd_word - SCR_WORD;
   assign rd_scr_hit = (rd_rel < WORD_W'(SCR_N));
   assign rd_idx     = rd_rel[IDX_W-1:0];

   // Read mux
   always_comb begin
      rd_data_c = '0;
      rd_resp_c = OKAY;
      if (rd_word == ID_WORD) begin
         rd_data_c = `AXIL_REGS_ID;
      end else if (rd_scr_hit) begin
         rd_data_c = scratch[rd_idx];
      end else if (rd_word == CNT_WORD) begin
         rd_data_c = wr_count;
      end else begin
         rd_resp_c = SLVERR;
      end
   end

   // ====================
   // Register state
   // ====================
   // Only scratch words are writable; anything else leaves state alone
   always_ff @(posedge axil_clk) begin
      if (rst) begin
         for (int i = 0; i < SCR_N; i++) begin
            scratch[i] <= '0;
         end
         wr_count <= '0;
      end else if (wr_stb && wr_scr_hit) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_req.strb[b]) begin
               scratch[wr_idx][8*b +: 8] <= wr_req.data[8*b +: 8];
            end
         end
         wr_count <= wr_count + 32'd1;
      end
   end

   // Result strobes trail the request strobes by one cycle
   always_ff @(posedge axil_clk) begin
      if (rst) begin
         wr_res_stb <= 1'b0;
         rd_res_stb <= 1'b0;
      end else begin
         wr_res_stb <= wr_stb;
         rd_res_stb <= rd_stb;
      end
   end

   always_ff @(posedge axil_clk) begin
      if (wr_stb) begin
         wr_resp <= wr_scr_hit ? OKAY : SLVERR;
      end
      if (rd_stb) begin
         rd_res.data <= rd_data_c;
         rd_res.resp <= rd_resp_c;
      end
   end

endmodule

// File: design/axil_resp_gen.sv
// ====================
// AXI-Lite response generator
// Holds B and R payloads until the master takes them
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module axil_resp_gen
   import axil_regs_pkg::*;
(
   input  logic         axil_clk,
   input  logic         rst,
   // Results from the register file
   input  logic         wr_res_stb,
   input  axil_resp_e   wr_resp,
   input  logic         rd_res_stb,
   input  axil_rd_res_t rd_res,
   // B channel
   output logic         bvalid,
   output logic [1:0]   bresp,
   input  logic         bready,
   // R channel
   output logic         rvalid,
   output logic [31:0]  rdata,
   output logic [1:0]   rresp,
   input  logic         rready,
   // Handshake done, back to capture
   output logic         wr_done,
   output logic         rd_done
);

   axil_resp_e   b_hold;
   axil_rd_res_t r_hold;

   assign wr_done = bvalid && bready;
   assign rd_done = rvalid && rready;

   assign bresp = b_hold;
   assign rdata = r_hold.data;
   assign rresp = r_hold.resp;

   // ====================
   // Valid flags
   // ====================
   always_ff @(posedge axil_clk) begin
      if (rst) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_res_stb) begin
            bvalid <= 1'b1;
         end else if (wr_done) begin
            bvalid <= 1'b0;
         end
         if (rd_res_stb) begin
            rvalid <= 1'b1;
         end else if (rd_done) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Loaded once per transaction, stable while valid is up
   always_ff @(posedge axil_clk) begin
      if (wr_res_stb) begin
         b_hold <= wr_resp;
      end
      if (rd_res_stb) begin
         r_hold <= rd_res;
      end
   end

endmodule

// File: design/axil_regs_top.sv
// ====================
// AXI-Lite register peripheral top level
// Capture, register file and response generator
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module axil_regs_top
   import axil_regs_pkg::*;
(
   input  logic                    axil_clk,
   input  logic                    rst,
   input  logic                    awvalid,
   input  logic [`AXIL_ADDR_W-1:0] awaddr,
   output logic                    awready,
   input  logic                    wvalid,
   input  logic [31:0]             wdata,
   input  logic [3:0]              wstrb,
   output logic                    wready,
   output logic                    bvalid,
   output logic [1:0]              bresp,
   input  logic                    bready,
   input  logic                    arvalid,
   input  logic [`AXIL_ADDR_W-1:0] araddr,
   output logic                    arready,
   output logic                    rvalid,
   output logic [31:0]             rdata,
   output logic [1:0]              rresp,
   input  logic                    rready
);

   // Capture to register file
   logic         wr_stb;
   axil_wr_req_t wr_req;
   logic         rd_stb;
   axil_rd_req_t rd_req;

   // Register file to response generator
   logic         wr_res_stb;
   axil_resp_e   wr_resp;
   logic         rd_res_stb;
   axil_rd_res_t rd_res;

   // Response generator back to capture
   logic         wr_done;
   logic         rd_done;

   axil_req_capture i_capture (
      .axil_clk (axil_clk),
      .rst      (rst),
      .awvalid  (awvalid),
      .awaddr   (awaddr),
      .awready  (awready),
      .wvalid   (wvalid),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wready   (wready),
      .arvalid  (arvalid),
      .araddr   (araddr),
      .arready  (arready),
      .wr_done  (wr_done),
      .rd_done  (rd_done),
      .wr_stb   (wr_stb),
      .wr_req   (wr_req),
      .rd_stb   (rd_stb),
      .rd_req   (rd_req)
   );

   axil_reg_file i_reg_file (
      .axil_clk   (axil_clk),
      .rst        (rst),
      .wr_stb     (wr_stb),
      .wr_req     (wr_req),
      .rd_stb     (rd_stb),
      .rd_req     (rd_req),
      .wr_res_stb (wr_res_stb),
      .wr_resp    (wr_resp),
      .rd_res_stb (rd_res_stb),
      .rd_res     (rd_res)
   );

   axil_resp_gen i_resp_gen (
      .axil_clk   (axil_clk),
      .rst        (rst),
      .wr_res_stb (wr_res_stb),
      .wr_resp    (wr_resp),
      .rd_res_stb (rd_res_stb),
      .rd_res     (rd_res),
      .bvalid     (bvalid),
      .bresp      (bresp),
      .bready     (bready),
      .rvalid     (rvalid),
      .rdata      (rdata),
      .rresp      (rresp),
      .rready     (rready),
      .wr_done    (wr_done),
      .rd_done    (rd_done)
   );

endmodule

// File: bench/axil_master_bfm.sv
// ====================
// AXI-Lite master model
// Queue-driven AW, W and AR channels, poke and peek tasks,
// random back-pressure on B and R
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module axil_master_bfm (
   input  logic                    axil_clk,
   input  logic                    rst,
   output logic                    awvalid,
   output logic [`AXIL_ADDR_W-1:0] awaddr,
   input  logic                    awready,
   output logic                    wvalid,
   output logic [31:0]             wdata,
   output logic [3:0]              wstrb,
   input  logic                    wready,
   input  logic                    bvalid,
   input  logic [1:0]              bresp,
   output logic                    bready,
   output logic                    arvalid,
   output logic [`AXIL_ADDR_W-1:0] araddr,
   input  logic                    arready,
   input  logic                    rvalid,
   input  logic [31:0]             rdata,
   input  logic [1:0]              rresp,
   output logic                    rready,
   // Some channel never saw its ready
   output logic                    hang
);

   localparam int HS_LIMIT   = 64;
   localparam int RESP_LIMIT = 256;

   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
      logic [7:0]              dly;
   } addr_cmd_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
      logic [7:0]  dly;
   } data_cmd_t;

   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  resp;
   } rd_beat_t;

   addr_cmd_t  aw_q [$];
   data_cmd_t  w_q [$];
   addr_cmd_t  ar_q [$];
   logic [1:0] b_q [$];
   rd_beat_t   r_q [$];

   logic       aw_hang;
   logic       w_hang;
   logic       ar_hang;
   integer     seed;

   assign hang = aw_hang || w_hang || ar_hang;

   // ====================
   // Request channels
   // ====================
   // Queues are polled on the rising edge once out of reset, beats driven on the falling one.
   // Ready is sampled mid-cycle, ahead of the edge that takes the beat.
   initial begin
      addr_cmd_t cmd;
      int        n;
      awvalid = 1'b0;
      awaddr  = '0;
      aw_hang = 1'b0;
      forever begin
         @(posedge axil_clk);
         if (!rst && aw_q.size() != 0) begin
            cmd = aw_q.pop_front();
            @(negedge axil_clk);
            repeat (cmd.dly) @(negedge axil_clk);
            awvalid = 1'b1;
            awaddr  = cmd.addr;
            n = 0;
            while (!awready && n < HS_LIMIT) begin
               @(negedge axil_clk);
               n++;
            end
            aw_hang = !awready;
            @(negedge axil_clk);
            awvalid = 1'b0;
         end
      end
   end

   initial begin
      data_cmd_t cmd;
      int        n;
      wvalid = 1'b0;
      wdata  = '0;
      wstrb  = '0;
      w_hang = 1'b0;
      forever begin
         @(posedge axil_clk);
         if (!rst && w_q.size() != 0) begin
            cmd = w_q.pop_front();
            @(negedge axil_clk);
            repeat (cmd.dly) @(negedge axil_clk);
            wvalid = 1'b1;
            wdata  = cmd.data;
            wstrb  = cmd.strb;
            n = 0;
            while (!wready && n < HS_LIMIT) begin
               @(negedge axil_clk);
               n++;
            end
            w_hang = !wready;
            @(negedge axil_clk);
            wvalid = 1'b0;
         end
      end
   end

   initial begin
      addr_cmd_t cmd;
      int        n;
      arvalid = 1'b0;
      araddr  = '0;
      ar_hang = 1'b0;
      forever begin
         @(posedge axil_clk);
         if (!rst && ar_q.size() != 0) begin
            cmd = ar_q.pop_front();
            @(negedge axil_clk);
            repeat (cmd.dly) @(negedge axil_clk);
            arvalid = 1'b1;
            araddr  = cmd.addr;
            n = 0;
            while (!arready && n < HS_LIMIT) begin
               @(negedge axil_clk);
               n++;
            end
            ar_hang = !arready;
            @(negedge axil_clk);
            arvalid = 1'b0;
         end
      end
   end

   // ====================
   // Response channels
   // ====================
   initial begin
      seed   = 12;
      bready = 1'b0;
      rready = 1'b0;
      forever begin
         @(negedge axil_clk);
         // Roughly one cycle in four stalls
         bready = (($random(seed) & 3) != 0);
         rready = (($random(seed) & 3) != 0);
         // Beat is taken at the coming edge
         if (bvalid && bready) begin
            b_q.push_back(bresp);
         end
         if (rvalid && rready) begin
            r_q.push_back({rdata, rresp});
         end
      end
   end

   // Positive w_lag puts W behind AW, negative puts W first
   task automatic poke(input logic [`AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input int w_lag,
                       output logic [1:0] resp, output bit timed_out);
      addr_cmd_t aw_cmd;
      data_cmd_t w_cmd;
      int        n;
      aw_cmd.addr = addr;
      aw_cmd.dly  = (w_lag < 0) ? 8'(-w_lag) : 8'd0;
      w_cmd.data  = data;
      w_cmd.strb  = strb;
      w_cmd.dly   = (w_lag > 0) ? 8'(w_lag) : 8'd0;
      aw_q.push_back(aw_cmd);
      w_q.push_back(w_cmd);
      n = 0;
      while (b_q.size() == 0 && n < RESP_LIMIT) begin
         @(negedge axil_clk);
         n++;
      end
      timed_out = (b_q.size() == 0);
      resp = 2'b00;
      if (!timed_out) begin
         resp = b_q.pop_front();
      end
   endtask

   task automatic peek(input logic [`AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
                       output logic [1:0] resp, output bit timed_out);
      addr_cmd_t ar_cmd;
      rd_beat_t  beat;
      int        n;
      ar_cmd.addr = addr;
      ar_cmd.dly  = 8'd0;
      ar_q.push_back(ar_cmd);
      n = 0;
      while (r_q.size() == 0 && n < RESP_LIMIT) begin
         @(negedge axil_clk);
         n++;
      end
      timed_out = (r_q.size() == 0);
      beat = '0;
      if (!timed_out) begin
         beat = r_q.pop_front();
      end
      data = beat.data;
      resp = beat.resp;
   endtask

endmodule

// File: bench/tb_axil_regs.sv
// ====================
// Testbench for the AXI-Lite register peripheral
// Reference model of the map, checks and pass/fail report
// ====================
`timescale 1ns/1ps

`include "axil_regs_config.svh"

module tb_axil_regs
   import axil_regs_pkg::*;
();

   logic                    axil_clk;
   logic                    rst;
   logic                    awvalid;
   logic [`AXIL_ADDR_W-1:0] awaddr;
   logic                    awready;
   logic                    wvalid;
   logic [31:0]             wdata;
   logic [3:0]              wstrb;
   logic                    wready;
   logic                    bvalid;
   logic [1:0]              bresp;
   logic                    bready;
   logic                    arvalid;
   logic [`AXIL_ADDR_W-1:0] araddr;
   logic                    arready;
   logic                    rvalid;
   logic [31:0]             rdata;
   logic [1:0]              rresp;
   logic                    rready;
   logic                    hang;

   // Reference model
   logic [31:0] model_scr [`AXIL_SCRATCH_N];
   logic [31:0] model_count;
   integer      seed;

   axil_regs_top i_dut (
      .axil_clk (axil_clk),
      .rst      (rst),
      .awvalid  (awvalid),
      .awaddr   (awaddr),
      .awready  (awready),
      .wvalid   (wvalid),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wready   (wready),
      .bvalid   (bvalid),
      .bresp    (bresp),
      .bready   (bready),
      .arvalid  (arvalid),
      .araddr   (araddr),
      .arready  (arready),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .rresp    (rresp),
      .rready   (rready)
   );

   axil_master_bfm i_master (
      .axil_clk (axil_clk),
      .rst      (rst),
      .awvalid  (awvalid),
      .awaddr   (awaddr),
      .awready  (awready),
      .wvalid   (wvalid),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wready   (wready),
      .bvalid   (bvalid),
      .bresp    (bresp),
      .bready   (bready),
      .arvalid  (arvalid),
      .araddr   (araddr),
      .arready  (arready),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .rresp    (rresp),
      .rready   (rready),
      .hang     (hang)
   );

   initial begin
      axil_clk = 1'b0;
      forever #4 axil_clk = ~axil_clk;
   end

   task automatic stop_with_fail();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERR %s expected %08h actual %08h", name, exp, act);
         stop_with_fail();
      end
   endtask

   // Scratch word index of an address, -1 outside the scratch block
   function automatic int scratch_index(input logic [31:0] addr);
      int rel;
      rel = int'(addr >> 2) - int'(`AXIL_SCRATCH_OFS >> 2);
      if (rel >= 0 && rel < `AXIL_SCRATCH_N) begin
         return rel;
      end
      return -1;
   endfunction

   task automatic write_and_check(input string name, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [3:0] strb,
                                  input int lag);
      logic [1:0] exp_resp;
      logic [1:0] resp;
      bit         timed_out;
      int         idx;
      idx = scratch_index(addr);
      exp_resp = (idx >= 0) ? OKAY : SLVERR;
      i_master.poke(addr, data, strb, lag, resp, timed_out);
      assert (!timed_out) else begin
         $display("%s: no write response arrived before the timeout", name);
         stop_with_fail();
      end
      check_value({name, " bresp"}, {30'd0, exp_resp}, {30'd0, resp});
      if (idx >= 0) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               model_scr[idx][8*b +: 8] = data[8*b +: 8];
            end
         end
         model_count = model_count + 32'd1;
      end
   endtask

   task automatic read_and_check(input string name, input logic [31:0] addr);
      logic [31:0] exp_data;
      logic [1:0]  exp_resp;
      logic [31:0] data;
      logic [1:0]  resp;
      bit          timed_out;
      int          idx;
      idx = scratch_index(addr);
      exp_data = '0;
      exp_resp = OKAY;
      if ((addr >> 2) == (`AXIL_ID_OFS >> 2)) begin
         exp_data = `AXIL_REGS_ID;
      end else if (idx >= 0) begin
         exp_data = model_scr[idx];
      end else if ((addr >> 2) == (`AXIL_WCOUNT_OFS >> 2)) begin
         exp_data = model_count;
      end else begin
         exp_resp = SLVERR;
      end
      i_master.peek(addr, data, resp, timed_out);
      assert (!timed_out) else begin
         $display("%s: no read response arrived before the timeout", name);
         stop_with_fail();
      end
      check_value({name, " rdata"}, exp_data, data);
      check_value({name, " rresp"}, {30'd0, exp_resp}, {30'd0, resp});
   endtask

   // ====================
   // Bus checks
   // ====================
   assert property (@(posedge axil_clk) disable iff (rst)
      (bvalid && !bready) |=> (bvalid && $stable(bresp)))
   else begin
      $display("B response changed or dropped while bready was low");
      stop_with_fail();
   end

   assert property (@(posedge axil_clk) disable iff (rst)
      (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
   else begin
      $display("R response changed or dropped while rready was low");
      stop_with_fail();
   end

   always @(posedge axil_clk) begin
      assert (!hang) else begin
         $display("Master gave up waiting for a ready on AW, W or AR");
         stop_with_fail();
      end
   end

   // ====================
   // Test sequence
   // ====================
   initial begin
      seed = 12;
      rst  = 1'b1;
      model_count = '0;
      for (int i = 0; i < `AXIL_SCRATCH_N; i++) begin
         model_scr[i] = '0;
      end
      repeat (4) @(negedge axil_clk);
      rst = 1'b0;

      assert (!bvalid && !rvalid && awready && wready && arready) else begin
         $display("Outputs after reset are not idle with all readies high");
         stop_with_fail();
      end
      read_and_check("id", `AXIL_ID_OFS);

      // Full words, twice over
      for (int pass_n = 0; pass_n < 2; pass_n++) begin
         for (int i = 0; i < `AXIL_SCRATCH_N; i++) begin
            write_and_check("scratch_full", `AXIL_SCRATCH_OFS + 32'(4 * i),
                            32'($random(seed)), 4'hf, 0);
         end
         for (int i = 0; i < `AXIL_SCRATCH_N; i++) begin
            read_and_check("scratch_full", `AXIL_SCRATCH_OFS + 32'(4 * i));
         end
      end

      for (int i = 0; i < `AXIL_SCRATCH_N; i++) begin
         write_and_check("scratch_partial", `AXIL_SCRATCH_OFS + 32'(4 * i),
                         32'($random(seed)), 4'($random(seed)), 0);
         read_and_check("scratch_partial", `AXIL_SCRATCH_OFS + 32'(4 * i));
      end

      write_and_check("read_only", `AXIL_ID_OFS, 32'hdead_beef, 4'hf, 0);
      write_and_check("read_only", `AXIL_WCOUNT_OFS, 32'h1234_5678, 4'hf, 0);
      write_and_check("read_only", `AXIL_WCOUNT_OFS + 32'd4, 32'h0bad_f00d, 4'hf, 0);
      read_and_check("read_only", `AXIL_ID_OFS);
      read_and_check("unmapped", `AXIL_WCOUNT_OFS + 32'd4);
      read_and_check("unmapped", 32'h0000_0100);
      read_and_check("count", `AXIL_WCOUNT_OFS);

      // W after, with and ahead of AW
      for (int lag = -2; lag <= 2; lag += 2) begin
         for (int i = 0; i < `AXIL_SCRATCH_N; i++) begin
            write_and_check("ordering", `AXIL_SCRATCH_OFS + 32'(4 * i),
                            32'($random(seed)), 4'($random(seed)), lag);
            read_and_check("ordering", `AXIL_SCRATCH_OFS + 32'(4 * i));
         end
      end

      fork
         write_and_check("overlap", `AXIL_SCRATCH_OFS, 32'($random(seed)), 4'hf, 1);
         read_and_check("overlap", `AXIL_SCRATCH_OFS + 32'd4);
      join
      read_and_check("overlap", `AXIL_SCRATCH_OFS);
      read_and_check("count", `AXIL_WCOUNT_OFS);

      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: sim.f
+incdir+design
design/axil_regs_pkg.sv
design/axil_req_capture.sv
design/axil_reg_file.sv
design/axil_resp_gen.sv
design/axil_regs_top.sv
bench/axil_master_bfm.sv
bench/tb_axil_regs.sv

// File: Makefile
# Verilator flow for the AXI-Lite register peripheral

TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_axil_regs
FILELIST = sim.f
OBJ_DIR  = obj_dir
PASS_MSG = PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in its output
sim:
	$(TOOL) --binary $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
